// ==== src.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fet_if.sv
rtl/frontend.sv
rtl/decoder.sv
rtl/execute.sv
rtl/csr.sv
rtl/crosp_core.sv
bench/core_checker.sv
bench/core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module core_tb -o core_sim
# an assertion stop ends the run with a nonzero status
./obj_dir/core_sim > sim.log 2>&1 || echo "SOME TESTS FAILED" >> sim.log
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
grep -q "ALL TESTS PASSED" sim.log

// ==== bench/core_tb.sv ====
/*
 * Random programs over x0..x7; x1..x7 are loaded first since the register
 * file has no reset. Branches only go forward, the last word jumps to itself.
 */
`include "core_config.svh"
`default_nettype none

module core_tb;
    localparam int PLEN = 24;
    localparam int NTEST = 5;
    localparam int LIMIT = NTEST * 40 * 10;
    localparam logic [31:0] LAST_PC = `CORE_RST_PC + 32'(4 * (PLEN - 1));

    logic clk, rst, imem_req, imem_ack, dbg_valid, mem_rst, mem_busy, fix_delay;
    logic [31:0] imem_addr, imem_data, dbg_pc, dbg_ir, dbg_wdat, lfsr;
    logic [4:0] dbg_rd;
    logic [63:0] dbg_cycle, prev_cycle;
    logic [31:0] prog [PLEN];
    logic [31:0] exp_pc [64], exp_ir [64], exp_wdat [64];
    logic [4:0] exp_rd [64];
    int exp_n, mem_wait, cycles, test_errs, n_pass, n_fail;

    crosp_core DUT (.*);

    bind crosp_core core_checker chk (.clk(clk), .rst(rst), .imem_req(imem_req),
        .imem_addr(imem_addr), .imem_ack(imem_ack), .dbg_valid(dbg_valid));

    always #2 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] prog_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `CORE_RST_PC) >> 2;
        return (idx < 32'(PLEN)) ? prog[int'(idx)] : prog[PLEN-1];
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(rand_bits(3));
    endfunction

    // kinds: 0 reg-reg, 1 imm, 2 lui, 3 branch, 4 jal, 5 csrrs minstret
    function automatic int pick_kind(input int mode);
        logic [2:0] r;
        r = 3'(rand_bits(3));
        case (mode)
            0: return (r < 3'd6) ? 0 : 1;
            1: return (r < 3'd3) ? 1 : ((r < 3'd6) ? 2 : 0);
            2: return (r < 3'd3) ? 3 : ((r < 3'd5) ? 4 : int'(r[0] == 1'b0));
            3: return (r < 3'd3) ? 5 : ((r < 3'd6) ? 0 : 1);
            default: return (r > 3'd5) ? int'(r) - 6 : int'(r);
        endcase
    endfunction

    task automatic gen_program(input int mode);
        logic [2:0] f3s [5];
        logic [31:0] off;
        int k;
        f3s = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100};
        for (int i = 0; i < 7; i++) begin
            prog[i] = {12'(rand_bits(12)), 5'd0, 3'b000, 5'(i + 1), 7'b0010011};
        end
        for (int i = 7; i < PLEN - 1; i++) begin
            k = int'(rand_bits(3)) % 5;
            off = 32'(4 * (1 + int'(rand_bits(4)) % (PLEN - 1 - i)));
            case (pick_kind(mode))
                0: prog[i] = {1'b0, k == 1, 5'd0, rand_reg(), rand_reg(), f3s[k],
                              rand_reg(), 7'b0110011};
                1: prog[i] = {12'(rand_bits(12)), rand_reg(), f3s[(k == 1) ? 4 : k],
                              rand_reg(), 7'b0010011};
                2: prog[i] = {20'(rand_bits(20)), rand_reg(), 7'b0110111};
                3: prog[i] = {off[12], off[10:5], rand_reg(), rand_reg(), 2'b00,
                              1'(rand_bits(1)), off[4:1], off[11], 7'b1100011};
                4: prog[i] = {off[20], off[10:1], off[11], off[19:12], rand_reg(),
                              7'b1101111};
                default: prog[i] = {12'hb02, 5'd0, 3'b010, rand_reg(), 7'b1110011};
            endcase
        end
        prog[PLEN-1] = 32'h0000_006f; // jal x0, 0
    endtask

    // ISA interpreter producing the expected retire list
    task automatic build_expected();
        logic [31:0] mreg [32];
        logic [31:0] pc, ir, a, b, val, nxt, imm;
        logic wen, stop;
        for (int i = 0; i < 32; i++) mreg[i] = '0;
        pc = `CORE_RST_PC;
        exp_n = 0;
        stop = 1'b0;
        while (!stop && exp_n < 64) begin
            ir = prog_word(pc);
            a = mreg[ir[19:15]];
            b = mreg[ir[24:20]];
            imm = {{20{ir[31]}}, ir[31:20]};
            nxt = pc + 32'd4;
            wen = 1'b1;
            val = '0;
            if (ir[6:0] == 7'b0010011) b = imm;
            case (ir[6:0])
                7'b0110011, 7'b0010011: begin
                    case (ir[14:12])
                        3'b000: val = (ir[5] && ir[30]) ? a - b : a + b;
                        3'b100: val = a ^ b;
                        3'b110: val = a | b;
                        default: val = a & b;
                    endcase
                end
                7'b0110111: val = {ir[31:12], 12'b0};
                7'b1100011: begin
                    wen = 1'b0;
                    if ((a == b) != ir[12])
                        nxt = pc + {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
                end
                7'b1101111: begin
                    val = pc + 32'd4; // link
                    nxt = pc + {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
                end
                default: val = 32'(exp_n); // minstret before this one
            endcase
            wen = wen && (ir[11:7] != 5'd0);
            if (wen) mreg[ir[11:7]] = val;
            exp_pc[exp_n] = pc;
            exp_ir[exp_n] = ir;
            exp_rd[exp_n] = wen ? ir[11:7] : 5'd0;
            exp_wdat[exp_n] = wen ? val : 32'd0;
            exp_n++;
            stop = (pc == LAST_PC);
            pc = nxt;
        end
    endtask

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %0h actual %0h", what, exp, act);
            test_errs++;
        end
    endtask

    task automatic run_test(input int t, input string name);
        int k;
        logic finished;
        test_errs = 0;
        fix_delay = (t == 4);
        gen_program(t);
        build_expected();
        @(posedge clk);
        #1 rst = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        k = 0;
        prev_cycle = '0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (dbg_cycle < prev_cycle) begin
                $display("%s: dbg_cycle went backwards", name);
                test_errs++;
            end
            prev_cycle = dbg_cycle;
            if (dbg_valid && k >= exp_n) begin
                $display("%s: more retires than the program allows", name);
                test_errs++;
                finished = 1'b1;
            end else if (dbg_valid) begin
                check($sformatf("%s #%0d pc", name, k), 64'(exp_pc[k]), 64'(dbg_pc));
                check($sformatf("%s #%0d ir", name, k), 64'(exp_ir[k]), 64'(dbg_ir));
                check($sformatf("%s #%0d rd", name, k), 64'(exp_rd[k]), 64'(dbg_rd));
                check($sformatf("%s #%0d wdat", name, k), 64'(exp_wdat[k]), 64'(dbg_wdat));
                finished = (dbg_pc == LAST_PC);
                k++;
            end
        end
        check($sformatf("%s retire count", name), 64'(exp_n), 64'(k));
        $display("%s: %s, %0d retires", name, (test_errs == 0) ? "ok" : "mismatch", k);
        if (test_errs == 0) n_pass++;
        else n_fail++;
    endtask

    // memory side of the four-phase port, driven 1 unit after the edge
    always @(posedge clk) begin
        mem_rst = rst;
        #1;
        if (mem_rst) begin
            imem_ack = 1'b0;
            mem_busy = 1'b0;
        end else if (imem_ack) begin
            if (!imem_req) imem_ack = 1'b0;
        end else if (imem_req) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = fix_delay ? 3 : int'(rand_bits(2));
            end
            if (mem_wait == 0) begin
                imem_data = prog_word(imem_addr);
                imem_ack = 1'b1;
                mem_busy = 1'b0;
            end else begin
                mem_wait--;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: final jump not retired within %0d cycles", LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        imem_ack = 1'b0;
        imem_data = '0;
        mem_busy = 1'b0;
        fix_delay = 1'b0;
        lfsr = 32'h87553207;
        cycles = 0;
        n_pass = 0;
        n_fail = 0;
        run_test(0, "alu_reg");
        run_test(1, "alu_imm_lui");
        run_test(2, "branch_jal");
        run_test(3, "csr_minstret");
        run_test(4, "slow_memory");
        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== bench/core_checker.sv ====
/*
 * Bound to crosp_core. Covers the four-phase imem rules and a quiet
 * retire port while reset is held.
 */
`default_nettype none

module core_checker (
    input logic        clk,
    input logic        rst,
    input logic        imem_req,
    input logic [31:0] imem_addr,
    input logic        imem_ack,
    input logic        dbg_valid
);
    req_held: assert property (@(posedge clk) disable iff (rst)
        imem_req && !imem_ack |=> imem_req)
        else $error("imem_req dropped before imem_ack rose");

    addr_stable: assert property (@(posedge clk) disable iff (rst)
        imem_req |=> !imem_req || $stable(imem_addr))
        else $error("imem_addr changed during a request");

    no_req_on_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(imem_req) |-> !$past(imem_ack)) // ack as seen when req was set
        else $error("imem_req rose while imem_ack was high");

    // first reset edge may still show the last retire
    quiet_in_rst: assert property (@(posedge clk)
        rst && $past(rst) |-> !dbg_valid)
        else $error("dbg_valid high during reset");
endmodule

`default_nettype wire

// ==== rtl/crosp_core.sv ====
/*
 * Single-issue RV32I subset core, one commit lane on the debug ports.
 * imem is four-phase req/ack; no loads, stores, traps or interrupts.
 */
`default_nettype none

module crosp_core import isa_pkg::*, pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    input  logic        imem_ack,
    input  logic [31:0] imem_data,
    output logic        dbg_valid,
    output logic [31:0] dbg_pc,
    output logic [31:0] dbg_ir,
    output logic [4:0]  dbg_rd,
    output logic [31:0] dbg_wdat,
    output logic [63:0] dbg_cycle
);
    dec_bundle_t dec;
    com_bundle_t com;
    red_bundle_t red;
    logic [11:0] csr_addr;
    logic [31:0] csr_rdat;

    fet_if fet();

    frontend fe_inst (
        .clk(clk), .rst(rst), .red(red), .fet(fet),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_ack(imem_ack), .imem_data(imem_data)
    );

    decoder dec_inst (
        .clk(clk), .rst(rst), .red(red), .fet(fet), .dec(dec)
    );

    execute exe_inst (
        .clk(clk), .rst(rst), .dec(dec),
        .csr_rdat(csr_rdat), .csr_addr(csr_addr),
        .com(com), .red(red)
    );

    csr csr_inst (
        .clk(clk), .rst(rst), .com(com),
        .csr_addr(csr_addr), .csr_rdat(csr_rdat), .cycle(dbg_cycle)
    );

    // retire lane
    assign dbg_valid = com.valid;
    assign dbg_pc = com.pc;
    assign dbg_ir = com.ir;
    assign dbg_rd = com.rd;
    assign dbg_wdat = com.wdat;
endmodule

`default_nettype wire

// ==== rtl/csr.sv ====
/*
 * Read-only mcycle and minstret. Reads return the low word; CSRRS set bits
 * are ignored. Unknown addresses read as zero.
 */
`default_nettype none

module csr import pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  com_bundle_t com,
    input  logic [11:0] csr_addr,
    output logic [31:0] csr_rdat,
    output logic [63:0] cycle
);
    localparam logic [11:0] MCYCLE = 12'hb00;
    localparam logic [11:0] MINSTRET = 12'hb02;

    logic [63:0] mcycle;
    logic [63:0] minstret;
    logic [63:0] instret_now;

    // the retire held in com has not been counted yet
    assign instret_now = minstret + 64'(com.valid);
    assign cycle = mcycle;

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 64'd1;
            if (com.valid) begin
                minstret <= minstret + 64'd1;
            end
        end
    end

    always_comb begin
        case (csr_addr)
            MCYCLE:   csr_rdat = mcycle[31:0];
            MINSTRET: csr_rdat = instret_now[31:0];
            default:  csr_rdat = 32'd0;
        endcase
    end
endmodule

`default_nettype wire

// ==== rtl/execute.sv ====
/*
 * In-order execute and retire, one instruction per cycle, no forwarding
 * needed since writeback happens in the same cycle. Instructions without a
 * register write retire with rd and wdat zero.
 */
`include "core_config.svh"
`default_nettype none

module execute import isa_pkg::*, pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  dec_bundle_t dec,
    input  logic [31:0] csr_rdat,
    output logic [11:0] csr_addr,
    output com_bundle_t com,
    output red_bundle_t red
);
    logic [31:0] rf [`CORE_NREG];
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic [31:0] wdat;
    logic        fire;
    logic        wr;
    logic        taken;

    // slot right after a taken branch is wrong-path
    assign fire = dec.valid && !red.valid;
    assign wr = dec.wen && (dec.rd != 5'd0);

    assign rs1_val = (dec.rs1 == 5'd0) ? 32'd0 : rf[dec.rs1];
    assign rs2_val = (dec.rs2 == 5'd0) ? 32'd0 : rf[dec.rs2];
    assign op_b = dec.use_imm ? dec.imm : rs2_val;
    assign csr_addr = dec.ir[31:20];

    always_comb begin
        case (dec.alu_op)
            SUB:     alu_res = rs1_val - op_b;
            AND:     alu_res = rs1_val & op_b;
            OR:      alu_res = rs1_val | op_b;
            XOR:     alu_res = rs1_val ^ op_b;
            PASS_B:  alu_res = op_b;
            default: alu_res = rs1_val + op_b;
        endcase
    end

    always_comb begin
        if (dec.is_jal) begin
            wdat = dec.pc + 32'd4; // link
        end else if (dec.is_csr) begin
            wdat = csr_rdat;
        end else begin
            wdat = alu_res;
        end
    end

    assign taken = dec.is_jal || (dec.is_branch && ((rs1_val == rs2_val) != dec.branch_ne));

    always_ff @(posedge clk) begin
        if (fire && wr) begin
            rf[dec.rd] <= wdat;
        end
    end

    always_ff @(posedge clk) begin
        com.pc <= dec.pc;
        com.ir <= dec.ir;
        com.rd <= wr ? dec.rd : 5'd0;
        com.wdat <= wr ? wdat : 32'd0;
        com.wen <= wr;
        red.pc <= dec.pc + dec.imm;
        if (rst) begin
            com.valid <= 1'b0;
            red.valid <= 1'b0;
        end else begin
            com.valid <= fire;
            red.valid <= fire && taken;
        end
    end
endmodule

`default_nettype wire

// ==== rtl/decoder.sv ====
/*
 * One instruction per cycle into a registered bundle. Unknown encodings
 * leave every flag and wen low, so they retire as no-ops.
 */
`default_nettype none

module decoder import isa_pkg::*, pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  red_bundle_t red,
    fet_if.decoder      fet,
    output dec_bundle_t dec
);
    opcode_t     opc;
    logic [2:0]  funct3;
    logic [31:0] ir;
    dec_bundle_t nxt;

    assign ir = fet.ir;
    assign opc = opcode_t'(ir[6:0]);
    assign funct3 = ir[14:12];
    assign fet.ready = 1'b1; // execute never stalls

    always_comb begin
        nxt = '0;
        nxt.valid = 1'b1;
        nxt.pc = fet.pc;
        nxt.ir = ir;
        nxt.rs1 = ir[19:15];
        nxt.rs2 = ir[24:20];
        nxt.rd = ir[11:7];
        nxt.alu_op = ADD;
        case (opc)
            OP, OP_IMM: begin
                nxt.use_imm = (opc == OP_IMM);
                nxt.imm = {{20{ir[31]}}, ir[31:20]};
                nxt.wen = 1'b1;
                case (funct3)
                    3'b000: nxt.alu_op = (opc == OP && ir[30]) ? SUB : ADD;
                    3'b100: nxt.alu_op = XOR;
                    3'b110: nxt.alu_op = OR;
                    3'b111: nxt.alu_op = AND;
                    default: nxt.wen = 1'b0;
                endcase
            end
            LUI: begin
                nxt.imm = {ir[31:12], 12'b0};
                nxt.use_imm = 1'b1;
                nxt.alu_op = PASS_B;
                nxt.wen = 1'b1;
            end
            BRANCH: begin
                nxt.imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
                nxt.is_branch = (funct3[2:1] == 2'b00); // beq, bne only
                nxt.branch_ne = funct3[0];
            end
            JAL: begin
                nxt.imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
                nxt.is_jal = 1'b1;
                nxt.wen = 1'b1;
            end
            SYSTEM: begin
                nxt.is_csr = (funct3 == 3'b010); // csrrs
                nxt.wen = (funct3 == 3'b010);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (fet.valid && fet.ready) begin
            dec <= nxt;
        end
        if (rst || red.valid) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= fet.valid && fet.ready;
        end
    end
endmodule

`default_nettype wire

// ==== rtl/frontend.sv ====
/*
 * Sequential fetch over a four-phase req/ack port, one transaction at a time.
 * A new request waits for ack low and a free buffer slot.
 * Replies to a request that was in flight at a redirect are dropped.
 */
`include "core_config.svh"
`default_nettype none

module frontend import pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  red_bundle_t red,
    fet_if.frontend     fet,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    input  logic        imem_ack,
    input  logic [31:0] imem_data
);
    localparam int PW = $clog2(`CORE_FQSZ);
    localparam int CW = $clog2(`CORE_FQSZ + 1);

    fet_state_t    state;
    logic [31:0]   pc;          // next fetch address
    logic          discard;
    logic [31:0]   buf_pc [`CORE_FQSZ];
    logic [31:0]   buf_ir [`CORE_FQSZ];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [CW-1:0] count;
    logic          issue;
    logic          fill;
    logic          pop;

    function automatic logic [PW-1:0] bump(input logic [PW-1:0] p);
        bump = (p == PW'(`CORE_FQSZ - 1)) ? '0 : p + 1'b1;
    endfunction

    assign imem_req = (state == REQ);
    assign issue = (state != REQ) && !imem_ack && !red.valid && (count < CW'(`CORE_FQSZ));
    assign fill = (state == REQ) && imem_ack && !discard && !red.valid;
    assign pop = fet.valid && fet.ready;

    assign fet.valid = (count != '0);
    assign fet.pc = buf_pc[rd_ptr];
    assign fet.ir = buf_ir[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            pc <= `CORE_RST_PC;
            discard <= 1'b0;
        end else begin
            case (state)
                REQ: begin
                    if (imem_ack) begin
                        state <= WAIT_LOW; // data taken, drop req
                    end
                end
                default: begin
                    if (issue) begin
                        state <= REQ;
                    end else if (!imem_ack) begin
                        state <= IDLE;
                    end
                end
            endcase
            if (red.valid) begin
                pc <= red.pc;
            end else if (issue) begin
                pc <= pc + 32'd4;
            end
            if (state == REQ && imem_ack) begin
                discard <= 1'b0;
            end else if (state == REQ && red.valid) begin
                discard <= 1'b1; // finish the handshake, ignore data
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            imem_addr <= pc;
        end
        if (fill) begin
            buf_pc[wr_ptr] <= imem_addr;
            buf_ir[wr_ptr] <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || red.valid) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (fill) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            count <= count + CW'(fill) - CW'(pop);
        end
    end
endmodule

`default_nettype wire

// ==== rtl/fet_if.sv ====
/*
 * Fetch-to-decode stream. A beat moves on any edge with valid and ready high.
 */
`default_nettype none

interface fet_if;
    logic        valid;
    logic        ready;
    logic [31:0] pc;
    logic [31:0] ir;

    modport frontend (output valid, output pc, output ir, input ready);

    modport decoder (input valid, input pc, input ir, output ready);
endinterface

`default_nettype wire

// ==== rtl/pipe_pkg.sv ====
/*
 * Pipeline bundles between frontend, decoder, execute and csr.
 * A redirect is valid for a single cycle.
 */
`default_nettype none

package pipe_pkg;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        REQ      = 2'd1, // req high, waiting for ack
        WAIT_LOW = 2'd2  // waiting for ack to drop
    } fet_state_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] ir;
        logic [4:0]  rd;
        logic [31:0] wdat;
        logic        wen;
    } com_bundle_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc; // target
    } red_bundle_t;

endpackage

`default_nettype wire

// ==== rtl/isa_pkg.sv ====
/*
 * RV32I subset seen by the decoder and execute stage.
 * Opcodes outside opcode_t decode as no-ops.
 */
`default_nettype none

package isa_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        AND    = 3'd2,
        OR     = 3'd3,
        XOR    = 3'd4,
        PASS_B = 3'd5 // lui
    } alu_op_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] ir;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic        use_imm;  // operand b from imm
        alu_op_t     alu_op;
        logic        is_branch;
        logic        branch_ne; // bne, else beq
        logic        is_jal;
        logic        is_csr;
        logic        wen;
    } dec_bundle_t;

endpackage

`default_nettype wire

// ==== rtl/core_config.svh ====
/*
 * Core build constants. The fetch buffer depth must be at least 2.
 * Only x0..x31 exist, so the register count stays at 32.
 */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// first fetch address out of reset
`define CORE_RST_PC 32'h0000_0000

`define CORE_NREG 32

`define CORE_FQSZ 2 // fetch buffer entries

`endif
